//--- dv/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int period            = 4;
    localparam int reset_cycles      = 16;
    localparam int mem_words         = 256;
    localparam int n_random          = 300;
    localparam int n_directed        = 16 + 18 + 52 + 12 + 18; // Sum over directed sections.
    localparam int cycles_per_access = 20;

    typedef struct packed {
        logic        err;
        logic [31:0] data;
    } result_t;

    logic                  clk;
    logic                  rst;
    logic                  valid;
    logic                  ren;
    logic                  wen;
    logic [data_width-1:0] addr;
    logic [data_width-1:0] wdata;
    mem_size_e             size;
    ext_mode_e             ext;
    logic [data_width-1:0] rdata;
    logic                  done;
    logic                  err;

    logic [31:0] shadow [mem_words];
    logic [31:0] lfsr_state = 32'hf1b0_f5b5;
    result_t     exp_q [$];
    result_t     exp_res;

    tb_clk_gen #(.period(period), .reset_cycles(reset_cycles)) u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    lsu_top #(.addr_width(32), .mem_words(mem_words)) i_dut (
        .clk   (clk),
        .rst   (rst),
        .valid (valid),
        .ren   (ren),
        .wen   (wen),
        .addr  (addr),
        .wdata (wdata),
        .size  (size),
        .ext   (ext),
        .rdata (rdata),
        .done  (done),
        .err   (err)
    );

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int size_bytes(input mem_size_e sz);
        case (sz)
            size_byte: return 1;
            size_half: return 2;
            default:   return 4;
        endcase
    endfunction

    function automatic logic access_ok(input logic [31:0] a, input mem_size_e sz);
        return ((a[1:0] % size_bytes(sz)) == 0) && (a[31:2] < mem_words);
    endfunction

    function automatic result_t expect_result(input logic is_write, input logic [31:0] a,
                                              input mem_size_e sz, input ext_mode_e ex);
        result_t     r;
        logic [31:0] word;
        logic [31:0] val;
        int          nb;
        int          off;
        int          b;
        nb     = size_bytes(sz);
        off    = a[1:0];
        r.err  = !access_ok(a, sz);
        r.data = '0;
        if (!r.err && !is_write) begin
            word = shadow[a[31:2]];
            val  = '0;
            for (b = 0; b < nb; b++) val[8*b +: 8] = word[8*(off+b) +: 8];
            if (ex == ext_sign && nb < 4 && val[8*nb-1]) begin
                for (b = nb; b < 4; b++) val[8*b +: 8] = 8'hff;
            end
            r.data = val;
        end
        return r;
    endfunction

    function automatic void store_shadow(input logic [31:0] a, input logic [31:0] d,
                                         input mem_size_e sz);
        int b;
        if (access_ok(a, sz)) begin
            for (b = 0; b < size_bytes(sz); b++) begin
                shadow[a[31:2]][8*(a[1:0]+b) +: 8] = d[8*b +: 8];
            end
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR %0t: %s mismatch, got %h expected %h", $time, what, got, expected);
            $display("Simulation failed");
            $fatal(1, "Check failed");
        end
    endtask

    // Drives one access and holds it for hold extra cycles after done.
    task automatic run_access(input logic is_write, input logic [31:0] a,
                              input logic [31:0] d, input mem_size_e sz,
                              input ext_mode_e ex, input int hold);
        exp_q.push_back(expect_result(is_write, a, sz, ex));
        if (is_write) store_shadow(a, d, sz);
        valid <= 1'b1;
        ren   <= !is_write;
        wen   <= is_write;
        addr  <= a;
        wdata <= d;
        size  <= sz;
        ext   <= ex;
        @(negedge clk);
        while (!done) @(negedge clk);
        repeat (hold) @(posedge clk);
        @(posedge clk);
        valid <= 1'b0;
        ren   <= 1'b0;
        wen   <= 1'b0;
        @(posedge clk);
    endtask

    task automatic store_access(input logic [31:0] a, input logic [31:0] d,
                                input mem_size_e sz);
        run_access(1'b1, a, d, sz, ext_sign, 0);
    endtask

    task automatic load_access(input logic [31:0] a, input mem_size_e sz, input ext_mode_e ex);
        run_access(1'b0, a, '0, sz, ex, 0);
    endtask

    // Compare each done against the oldest expected result.
    always @(negedge clk) begin
        if (!rst && done) begin
            if (exp_q.size() == 0) begin
                $display("Done seen at %0t with no access pending", $time);
                $display("Simulation failed");
                $fatal(1, "Extra done");
            end else begin
                exp_res = exp_q.pop_front();
                check_value($sformatf("rdata at addr %h", addr), rdata, exp_res.data);
                check_value($sformatf("err at addr %h", addr), {31'b0, err}, {31'b0, exp_res.err});
            end
        end
    end

    initial begin
        #((reset_cycles + (n_directed + n_random) * cycles_per_access) * period);
        $display("Timeout: accesses did not complete in the allowed time");
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        int          i;
        int          off;
        int          idx;
        int          hold;
        logic [31:0] a;
        logic [31:0] d;
        logic [2:0]  sel;
        logic [1:0]  s;
        logic        op;
        logic [31:0] oor [4];
        oor = '{32'd256, 32'd257, 32'd1000, 32'h3fff_ffff};
        valid = 1'b0;
        ren   = 1'b0;
        wen   = 1'b0;
        addr  = '0;
        wdata = '0;
        size  = size_word;
        ext   = ext_sign;
        for (i = 0; i < mem_words; i++) shadow[i] = '0; // Memory resets to zero.
        wait (!rst);
        @(posedge clk);

        for (i = 0; i < 8; i++) begin
            store_access(i * 4, rand_bits(32), size_word);
            load_access(i * 4, size_word, ext_sign);
        end

        for (off = 0; off < 4; off++) begin
            store_access((8 + off) * 4, 32'h8877_6655, size_word);
            store_access((8 + off) * 4 + off, rand_bits(32), size_byte);
            load_access((8 + off) * 4, size_word, ext_sign);
        end
        for (off = 0; off < 4; off += 2) begin
            store_access((12 + off) * 4, 32'h4433_2211, size_word);
            store_access((12 + off) * 4 + off, rand_bits(32), size_half);
            load_access((12 + off) * 4, size_word, ext_sign);
        end

        for (i = 0; i < 4; i++) begin
            store_access((20 + i) * 4, rand_bits(32), size_word);
            for (off = 0; off < 4; off++) begin
                load_access((20 + i) * 4 + off, size_byte, ext_sign);
                load_access((20 + i) * 4 + off, size_byte, ext_zero);
            end
            for (off = 0; off < 4; off += 2) begin
                load_access((20 + i) * 4 + off, size_half, ext_sign);
                load_access((20 + i) * 4 + off, size_half, ext_zero);
            end
        end

        store_access(40 * 4, 32'h5a5a_c3c3, size_word);
        for (off = 1; off < 4; off += 2) begin
            store_access(40 * 4 + off, 32'hffff_ffff, size_half);
            load_access(40 * 4 + off, size_half, ext_zero);
        end
        for (off = 1; off < 4; off++) begin
            store_access(40 * 4 + off, 32'hffff_ffff, size_word);
            load_access(40 * 4 + off, size_word, ext_sign);
        end
        load_access(40 * 4, size_word, ext_sign);

        for (i = 0; i < 4; i++) begin
            store_access(oor[i] << 2, rand_bits(32), size_word);
            load_access(oor[i] << 2, size_word, ext_sign);
            load_access((oor[i] << 2) + 3, size_byte, ext_sign);
            load_access((oor[i] << 2) + 2, size_half, ext_zero);
        end
        load_access(0, size_word, ext_sign); // Index 256 must not alias.
        load_access(4, size_word, ext_sign);

        for (i = 0; i < n_random; i++) begin
            sel = 3'(rand_bits(3));
            if (sel == 0) begin
                idx = 256 + rand_bits(10);
            end else if (sel == 1) begin
                idx = rand_bits(8);
            end else begin
                idx = rand_bits(4); // Small window for read-after-write.
            end
            off  = rand_bits(2);
            a    = (idx << 2) | off;
            s    = 2'(rand_bits(2));
            op   = 1'(rand_bits(1));
            d    = rand_bits(32);
            hold = rand_bits(2);
            run_access(op, a, d, (s == 2'd3) ? size_word : mem_size_e'(s),
                       ext_mode_e'(rand_bits(1)), hold);
        end

        repeat (4) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period       = 4,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0; // Released on a rising edge.
    end

endmodule

//--- filelist.f
verilog/lsu_pkg.sv
verilog/simple_bus_if.sv
verilog/lsu.sv
verilog/sbus_axil_bridge.sv
verilog/axil_sram.sv
verilog/lsu_top.sv
dv/tb_clk_gen.sv
dv/lsu_tb.sv

//--- verilog/axil_sram.sv
`timescale 1ns/1ps

module axil_sram #(
    parameter int addr_width = 32,
    parameter int mem_words  = 256
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [addr_width-1:0]          awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [lsu_pkg::data_width-1:0] wdata,
    input  logic [3:0]                     wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    input  logic [addr_width-1:0]          araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [lsu_pkg::data_width-1:0] rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready
);
    import lsu_pkg::*;

    localparam int idx_width = $clog2(mem_words);
    localparam logic [addr_width-3:0] depth = (addr_width-2)'(mem_words);

    logic [data_width-1:0] mem [mem_words];
    logic                  wr_fire;
    logic                  rd_fire;
    logic                  wr_in_range;
    logic                  rd_in_range;
    logic [idx_width-1:0]  wr_idx;
    logic [idx_width-1:0]  rd_idx;

    assign wr_fire = awvalid & wvalid & ~bvalid; // One write in flight.
    assign rd_fire = arvalid & ~rvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign arready = rd_fire;

    assign wr_in_range = awaddr[addr_width-1:2] < depth;
    assign rd_in_range = araddr[addr_width-1:2] < depth;
    assign wr_idx      = awaddr[idx_width+1:2];
    assign rd_idx      = araddr[idx_width+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_fire && wr_in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0; // Held until taken.
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_in_range ? resp_okay : resp_decerr;
        end
        if (rd_fire) begin
            rresp <= rd_in_range ? resp_okay : resp_decerr;
            rdata <= rd_in_range ? mem[rd_idx] : '0;
        end
    end

    a_wstrb_set : assert property (
        @(posedge clk) disable iff (rst) wvalid |-> wstrb != 4'b0000
    );

endmodule

//--- verilog/lsu.sv
`timescale 1ns/1ps

module lsu #(
    parameter int addr_width = 32
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             valid,
    input  logic                             ren,
    input  logic                             wen,
    input  logic [lsu_pkg::data_width-1:0]   addr,
    input  logic [lsu_pkg::data_width-1:0]   wdata,
    input  lsu_pkg::mem_size_e               size,
    input  lsu_pkg::ext_mode_e               ext,
    output logic [lsu_pkg::data_width-1:0]   rdata,
    output logic                             done,
    output logic                             err,
    simple_bus_if.master                     bus
);
    import lsu_pkg::*;

    logic                  ren_q;
    logic                  wen_q;
    logic                  rd_start;
    logic                  wr_start;
    logic                  misaligned;
    logic                  mis_done_q;
    logic [4:0]            lane_shift;
    logic [3:0]            strb;
    logic [data_width-1:0] rd_shifted;
    logic [data_width-1:0] load_val;

    always_ff @(posedge clk) begin
        if (rst) begin
            ren_q      <= 1'b0;
            wen_q      <= 1'b0;
            mis_done_q <= 1'b0;
        end else begin
            ren_q      <= valid & ren;
            wen_q      <= valid & wen;
            mis_done_q <= (rd_start | wr_start) & misaligned;
        end
    end

    assign rd_start = valid & ren & ~ren_q; // Rising edge only.
    assign wr_start = valid & wen & ~wen_q;

    assign misaligned = ((size == size_half) && addr[0]) ||
                        ((size == size_word) && (addr[1:0] != 2'b00));

    assign lane_shift = {addr[1:0], 3'b000};

    always_comb begin
        case (size)
            size_byte: strb = 4'b0001 << addr[1:0];
            size_half: strb = 4'b0011 << addr[1:0];
            default:   strb = 4'b1111;
        endcase
    end

    assign bus.wr_req  = wr_start & ~misaligned;
    assign bus.wr_addr = addr[addr_width-1:0];
    assign bus.wr_data = wdata << lane_shift; // Move data onto its lanes.
    assign bus.wr_strb = strb;

    assign bus.rd_req  = rd_start & ~misaligned;
    assign bus.rd_addr = addr[addr_width-1:0];
    assign bus.rd_size = size;

    // Addressed byte or halfword down to bit 0, then extend.
    assign rd_shifted = bus.rd_data >> lane_shift;

    always_comb begin
        case (size)
            size_byte: begin
                if (ext == ext_sign) begin
                    load_val = {{24{rd_shifted[7]}}, rd_shifted[7:0]};
                end else begin
                    load_val = {24'b0, rd_shifted[7:0]};
                end
            end
            size_half: begin
                if (ext == ext_sign) begin
                    load_val = {{16{rd_shifted[15]}}, rd_shifted[15:0]};
                end else begin
                    load_val = {16'b0, rd_shifted[15:0]};
                end
            end
            default: load_val = bus.rd_data;
        endcase
    end

    assign rdata = bus.rd_done ? load_val : '0;
    assign done  = mis_done_q | bus.wr_done | bus.rd_done;
    assign err   = mis_done_q |
                   ((bus.wr_done | bus.rd_done) && (bus.resp != resp_okay));

    a_one_direction : assert property (
        @(posedge clk) disable iff (rst) valid |-> !(ren && wen)
    );

endmodule

//--- verilog/lsu_pkg.sv
package lsu_pkg;

    localparam int data_width = 32; // Four byte lanes.

    // Same code as the AXI size field.
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } mem_size_e;

    typedef enum logic {
        ext_sign = 1'b0,
        ext_zero = 1'b1
    } ext_mode_e;

    // AXI response encoding.
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } bus_resp_e;

endpackage

//--- verilog/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
    parameter int addr_width = 32,
    parameter int mem_words  = 256
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           valid,
    input  logic                           ren,
    input  logic                           wen,
    input  logic [lsu_pkg::data_width-1:0] addr,
    input  logic [lsu_pkg::data_width-1:0] wdata,
    input  lsu_pkg::mem_size_e             size,
    input  lsu_pkg::ext_mode_e             ext,
    output logic [lsu_pkg::data_width-1:0] rdata,
    output logic                           done,
    output logic                           err
);
    import lsu_pkg::*;

    logic [addr_width-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [data_width-1:0] axi_wdata;
    logic [3:0]            wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [addr_width-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [data_width-1:0] axi_rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    simple_bus_if #(.addr_width(addr_width)) lsu_bus ();

    lsu #(.addr_width(addr_width)) u_lsu (
        .clk   (clk),
        .rst   (rst),
        .valid (valid),
        .ren   (ren),
        .wen   (wen),
        .addr  (addr),
        .wdata (wdata),
        .size  (size),
        .ext   (ext),
        .rdata (rdata),
        .done  (done),
        .err   (err),
        .bus   (lsu_bus)
    );

    sbus_axil_bridge #(.addr_width(addr_width)) u_bridge (
        .clk     (clk),
        .rst     (rst),
        .sbus    (lsu_bus),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (axi_wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (axi_rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    axil_sram #(
        .addr_width (addr_width),
        .mem_words  (mem_words)
    ) u_sram (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (axi_wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (axi_rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

//--- verilog/sbus_axil_bridge.sv
`timescale 1ns/1ps

module sbus_axil_bridge #(
    parameter int addr_width = 32
) (
    input  logic                           clk,
    input  logic                           rst,
    simple_bus_if.slave                    sbus,
    output logic [addr_width-1:0]          awaddr,
    output logic                           awvalid,
    input  logic                           awready,
    output logic [lsu_pkg::data_width-1:0] wdata,
    output logic [3:0]                     wstrb,
    output logic                           wvalid,
    input  logic                           wready,
    input  logic [1:0]                     bresp,
    input  logic                           bvalid,
    output logic                           bready,
    output logic [addr_width-1:0]          araddr,
    output logic                           arvalid,
    input  logic                           arready,
    input  logic [lsu_pkg::data_width-1:0] rdata,
    input  logic [1:0]                     rresp,
    input  logic                           rvalid,
    output logic                           rready
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_resp
    } state_e;

    state_e                wr_state;
    state_e                rd_state;
    logic                  wr_done_q;
    logic                  rd_done_q;
    logic [3:0]            rd_lane_q;
    logic [data_width-1:0] rd_data_q;
    bus_resp_e             resp_q;

    assign bready = 1'b1;
    assign rready = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state  <= st_idle;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            wr_done_q <= 1'b0;
        end else begin
            wr_done_q <= 1'b0;
            case (wr_state)
                st_idle: begin
                    if (sbus.wr_req) begin
                        awvalid  <= 1'b1;
                        wvalid   <= 1'b1;
                        wr_state <= st_addr;
                    end
                end
                st_addr: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if ((awready || !awvalid) && (wready || !wvalid)) begin
                        wr_state <= st_resp; // Both channels accepted.
                    end
                end
                st_resp: begin
                    if (bvalid) begin
                        wr_done_q <= 1'b1;
                        wr_state  <= st_idle;
                    end
                end
                default: wr_state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state  <= st_idle;
            arvalid   <= 1'b0;
            rd_done_q <= 1'b0;
        end else begin
            rd_done_q <= 1'b0;
            case (rd_state)
                st_idle: begin
                    if (sbus.rd_req) begin
                        arvalid  <= 1'b1;
                        rd_state <= st_addr;
                    end
                end
                st_addr: begin
                    if (arready) begin
                        arvalid  <= 1'b0;
                        rd_state <= st_resp;
                    end
                end
                st_resp: begin
                    if (rvalid) begin
                        rd_done_q <= 1'b1;
                        rd_state  <= st_idle;
                    end
                end
                default: rd_state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sbus.wr_req && wr_state == st_idle) begin
            awaddr <= sbus.wr_addr;
            wdata  <= sbus.wr_data;
            wstrb  <= sbus.wr_strb;
        end
        if (sbus.rd_req && rd_state == st_idle) begin
            araddr <= sbus.rd_addr;
            case (sbus.rd_size)
                size_byte: rd_lane_q <= 4'b0001 << sbus.rd_addr[1:0];
                size_half: rd_lane_q <= 4'b0011 << sbus.rd_addr[1:0];
                default:   rd_lane_q <= 4'b1111;
            endcase
        end
        if (wr_state == st_resp && bvalid) begin
            resp_q <= bus_resp_e'(bresp);
        end else if (rd_state == st_resp && rvalid) begin
            resp_q <= bus_resp_e'(rresp);
        end
        if (rd_state == st_resp && rvalid) begin
            rd_data_q <= rdata & {{8{rd_lane_q[3]}}, {8{rd_lane_q[2]}},
                                  {8{rd_lane_q[1]}}, {8{rd_lane_q[0]}}}; // Unused lanes zero.
        end
    end

    assign sbus.wr_done = wr_done_q;
    assign sbus.rd_done = rd_done_q;
    assign sbus.rd_data = rd_data_q;
    assign sbus.resp    = resp_q;

    a_wr_not_busy : assert property (
        @(posedge clk) disable iff (rst) sbus.wr_req |-> wr_state == st_idle
    );

    a_rd_not_busy : assert property (
        @(posedge clk) disable iff (rst) sbus.rd_req |-> rd_state == st_idle
    );

endmodule

//--- verilog/simple_bus_if.sv
`timescale 1ns/1ps

interface simple_bus_if #(
    parameter int addr_width = 32
);
    import lsu_pkg::*;

    logic                  wr_req;
    logic [addr_width-1:0] wr_addr;
    logic [data_width-1:0] wr_data;
    logic [3:0]            wr_strb;
    logic                  wr_done;

    logic                  rd_req;
    logic [addr_width-1:0] rd_addr;
    mem_size_e             rd_size;
    logic                  rd_done;
    logic [data_width-1:0] rd_data;

    bus_resp_e             resp; // Valid with either done pulse.

    modport master (
        output wr_req, wr_addr, wr_data, wr_strb,
        output rd_req, rd_addr, rd_size,
        input  wr_done, rd_done, rd_data, resp
    );

    modport slave (
        input  wr_req, wr_addr, wr_data, wr_strb,
        input  rd_req, rd_addr, rd_size,
        output wr_done, rd_done, rd_data, resp
    );

endinterface
